// File: sources.f
+incdir+source
source/isa_pkg.sv
source/rs_types_pkg.sv
source/cdb_if.sv
source/rs_entry.sv
source/rs_bank.sv
source/exec_unit.sv
source/cdb_arbiter.sv
source/rs_top.sv
verification/rs_tb.sv

// File: verification/rs_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module rs_tb;

    localparam int N_OPS   = 200;              // instructions dispatched in the run
    localparam int TIMEOUT = 500;              // cycles any single wait may take
    localparam int N_TAGS  = 1 << `TAG_BITS;

    logic                 clock;
    logic                 reset;
    logic                 dispatch_alu_valid;
    logic                 dispatch_mul_valid;
    logic [31:0]          dispatch_inst;
    logic                 dispatch_rs1_waiting;
    logic [`TAG_BITS-1:0] dispatch_rs1_tag;
    logic [`XLEN-1:0]     dispatch_rs1_value;
    logic                 dispatch_rs2_waiting;
    logic [`TAG_BITS-1:0] dispatch_rs2_tag;
    logic [`XLEN-1:0]     dispatch_rs2_value;
    logic [`TAG_BITS-1:0] dispatch_dest_tag;
    logic                 alu_credit;
    logic                 mul_credit;
    logic                 cdb_valid;
    logic [`TAG_BITS-1:0] cdb_tag;
    logic [`XLEN-1:0]     cdb_value;

    logic [31:0]      lfsr_state;
    logic [`XLEN-1:0] exp_value [N_OPS];   // reference result per dispatch
    int               dep1 [N_OPS];        // producer dispatch of rs1 or -1
    int               dep2 [N_OPS];
    bit               done [N_OPS];        // seen on the cdb
    bit               tag_busy [N_TAGS];   // dispatched and not yet broadcast
    int               tag_id [N_TAGS];     // dispatch currently owning the tag
    int               alu_credits;         // credits held by the dispatcher
    int               mul_credits;
    int               bcast_count;

    rs_top i_rs_top (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period
    end

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // first tag from a random start whose busy flag matches or -1
    function automatic int find_tag(input bit want_busy);
        int start;
        start = int'(take_bits(`TAG_BITS));
        for (int i = 0; i < N_TAGS; i++) begin
            if (tag_busy[(start + i) % N_TAGS] == want_busy) return (start + i) % N_TAGS;
        end
        return -1;
    endfunction

    // expected result straight from the rv32 encoding
    function automatic logic [`XLEN-1:0] ref_result(input logic [31:0] inst,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b_reg, input bit is_mul);
        logic [`XLEN-1:0]        b;
        logic [`XLEN-1:0]        res;
        logic signed [`XLEN-1:0] sra;
        logic                    alt;
        if (is_mul) return a * b_reg;  // low half of the product
        if (inst[5]) begin            // register-register
            b   = b_reg;
            alt = inst[30];
        end else begin                // sign extended imm12
            b   = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            alt = 1'b0;
        end
        sra = $signed(a) >>> b[4:0];
        case (inst[14:12])
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? sra : a >> b[4:0];
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    // one broadcast against the pending dispatch that owns its tag
    task automatic check_word(input rs_types_pkg::cdb_word_t actual);
        int id;
        if (!tag_busy[actual.tag])
            stop_run($sformatf("tag %0d was broadcast at %0t with no dispatch pending",
                               actual.tag, $time));
        id = tag_id[actual.tag];
        if ((dep1[id] >= 0 && !done[dep1[id]]) || (dep2[id] >= 0 && !done[dep2[id]]))
            stop_run($sformatf("tag %0d was broadcast at %0t before its source tag",
                               actual.tag, $time));
        if (actual.value !== exp_value[id])
            stop_run($sformatf("Fail at %0t: cdb_value (tag %0d) expected %h, got %h",
                               $time, actual.tag, exp_value[id], actual.value));
    endtask

    task automatic check_credit(input string name, input int held, input bit drained);
        if (drained && held != `RS_DEPTH)
            stop_run($sformatf("Fail at %0t: %s count expected %0d, got %0d",
                               $time, name, `RS_DEPTH, held));
        else if (held > `RS_DEPTH)
            stop_run($sformatf("at %0t the %s pulses gave back more credits than slots exist",
                               $time, name));
    endtask

    // waiting source on a pending tag or a plain value
    task automatic pick_operand(output logic waiting, output logic [`TAG_BITS-1:0] tag,
            output logic [`XLEN-1:0] value, output logic [`XLEN-1:0] known, output int dep);
        int t;
        t = -1;
        if (take_bits(1) != 0) t = find_tag(1'b1);
        value = take_bits(32);  // garbage when waiting
        if (t >= 0) begin
            waiting = 1'b1;
            tag     = t[`TAG_BITS-1:0];
            dep     = tag_id[t];
            known   = exp_value[dep];
        end else begin
            waiting = 1'b0;
            tag     = `TAG_BITS'(take_bits(`TAG_BITS));
            dep     = -1;
            known   = value;
        end
    endtask

    task automatic dispatch_op(input int id);
        bit               to_mul;
        int               dest;
        int               cycles;
        int               d1;
        int               d2;
        logic [2:0]       f3;
        logic [11:0]      imm;
        logic [14:0]      regs;
        logic [31:0]      inst;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        to_mul = take_bits(1) != 0;
        cycles = 0;
        dest   = find_tag(1'b0);
        while (((to_mul ? mul_credits : alu_credits) == 0) || dest < 0) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > TIMEOUT) stop_run("no credit or free tag came back in time");
            dest = find_tag(1'b0);
        end
        regs = 15'(take_bits(15));  // rs2 rs1 rd fields that the units ignore
        f3   = 3'(take_bits(3));
        if (f3 == 3'b011) f3 = 3'b000;  // sltu is outside the subset
        if (to_mul) begin
            inst = {7'b0000001, regs[14:10], regs[9:5], 3'b000, regs[4:0], 7'b0110011};
        end else if (take_bits(1) != 0) begin  // r view
            inst = {1'b0, (take_bits(1) != 0) && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                    regs[14:10], regs[9:5], f3, regs[4:0], 7'b0110011};
        end else begin                          // i view
            imm = 12'(take_bits(12));
            if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = '0;  // shamt only
            inst = {imm, regs[9:5], f3, regs[4:0], 7'b0010011};
        end
        pick_operand(dispatch_rs1_waiting, dispatch_rs1_tag, dispatch_rs1_value, a, d1);
        pick_operand(dispatch_rs2_waiting, dispatch_rs2_tag, dispatch_rs2_value, b, d2);
        dispatch_inst      = inst;
        dispatch_dest_tag  = dest[`TAG_BITS-1:0];
        dispatch_alu_valid = !to_mul;
        dispatch_mul_valid = to_mul;
        exp_value[id] = ref_result(inst, a, b, to_mul);
        dep1[id]      = d1;
        dep2[id]      = d2;
        done[id]      = 1'b0;
        tag_busy[dest] = 1'b1;
        tag_id[dest]   = id;
        if (to_mul) mul_credits--;
        else        alu_credits--;
        @(posedge clock);
        #1;
        dispatch_alu_valid = 1'b0;
        dispatch_mul_valid = 1'b0;
    endtask

    // credit returns and broadcasts sampled on the edge
    always @(posedge clock) begin
        rs_types_pkg::cdb_word_t seen;
        int                      id;
        if (!reset) begin
            if (alu_credit) begin
                alu_credits++;
                check_credit("alu_credit", alu_credits, 1'b0);
            end
            if (mul_credit) begin
                mul_credits++;
                check_credit("mul_credit", mul_credits, 1'b0);
            end
            if (cdb_valid) begin
                seen.tag   = cdb_tag;
                seen.value = cdb_value;
                check_word(seen);
                id                = tag_id[cdb_tag];
                done[id]          = 1'b1;
                tag_busy[cdb_tag] = 1'b0;  // free for reuse
                bcast_count++;
            end
        end
    end

    initial begin
        int cycles;
        lfsr_state           = 32'h6ede;
        reset                = 1'b1;
        dispatch_alu_valid   = 1'b0;
        dispatch_mul_valid   = 1'b0;
        dispatch_inst        = '0;
        dispatch_rs1_waiting = 1'b0;
        dispatch_rs1_tag     = '0;
        dispatch_rs1_value   = '0;
        dispatch_rs2_waiting = 1'b0;
        dispatch_rs2_tag     = '0;
        dispatch_rs2_value   = '0;
        dispatch_dest_tag    = '0;
        alu_credits = `RS_DEPTH;
        mul_credits = `RS_DEPTH;
        bcast_count = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            tag_busy[t] = 1'b0;
            tag_id[t]   = -1;
        end
        repeat (5) @(posedge clock);
        #1 reset = 1'b0;
        for (int i = 0; i < N_OPS; i++) dispatch_op(i);
        cycles = 0;
        while (bcast_count < N_OPS) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > TIMEOUT) stop_run("results still outstanding at the timeout");
        end
        repeat (20) @(posedge clock);  // any stray broadcast trips the checker
        check_credit("alu_credit", alu_credits, 1'b1);
        check_credit("mul_credit", mul_credits, 1'b1);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rs_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module rs_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_alu_valid,
    input  logic                 dispatch_mul_valid,
    input  logic [31:0]          dispatch_inst,
    input  logic                 dispatch_rs1_waiting,
    input  logic [`TAG_BITS-1:0] dispatch_rs1_tag,
    input  logic [`XLEN-1:0]     dispatch_rs1_value,
    input  logic                 dispatch_rs2_waiting,
    input  logic [`TAG_BITS-1:0] dispatch_rs2_tag,
    input  logic [`XLEN-1:0]     dispatch_rs2_value,
    input  logic [`TAG_BITS-1:0] dispatch_dest_tag,
    output logic                 alu_credit,
    output logic                 mul_credit,
    output logic                 cdb_valid,
    output logic [`TAG_BITS-1:0] cdb_tag,
    output logic [`XLEN-1:0]     cdb_value
);

    rs_types_pkg::dispatch_t dispatch;  // one packet shared by both stations
    rs_types_pkg::issue_t    alu_issue;
    rs_types_pkg::issue_t    mul_issue;
    logic                    alu_issue_valid;
    logic                    mul_issue_valid;
    logic                    alu_accept;
    logic                    mul_accept;

    cdb_if   cdb_bus ();
    unit_req alu_req ();
    unit_req mul_req ();

    always_comb begin
        dispatch.inst        = dispatch_inst;
        dispatch.rs1.waiting = dispatch_rs1_waiting;
        dispatch.rs1.tag     = dispatch_rs1_tag;
        dispatch.rs1.value   = dispatch_rs1_value;
        dispatch.rs2.waiting = dispatch_rs2_waiting;
        dispatch.rs2.tag     = dispatch_rs2_tag;
        dispatch.rs2.value   = dispatch_rs2_value;
        dispatch.dest        = dispatch_dest_tag;
    end

    rs_bank i_alu_bank (
        .clock (clock), .reset (reset),
        .dispatch_valid (dispatch_alu_valid), .dispatch (dispatch), .cdb (cdb_bus),
        .accept (alu_accept), .issue_valid (alu_issue_valid), .issue (alu_issue),
        .credit (alu_credit)
    );

    rs_bank i_mul_bank (
        .clock (clock), .reset (reset),
        .dispatch_valid (dispatch_mul_valid), .dispatch (dispatch), .cdb (cdb_bus),
        .accept (mul_accept), .issue_valid (mul_issue_valid), .issue (mul_issue),
        .credit (mul_credit)
    );

    exec_unit #(.STAGES(1)) i_alu (
        .clock (clock), .reset (reset), .in_valid (alu_issue_valid),
        .in_op (alu_issue), .accept (alu_accept), .req (alu_req)
    );

    exec_unit #(.STAGES(`MUL_STAGES)) i_mul (
        .clock (clock), .reset (reset), .in_valid (mul_issue_valid),
        .in_op (mul_issue), .accept (mul_accept), .req (mul_req)
    );

    cdb_arbiter i_arbiter (
        .clock (clock), .reset (reset),
        .alu_req (alu_req), .mul_req (mul_req), .cdb (cdb_bus)
    );

    // broadcast leaves the design as it wakes the stations
    assign cdb_valid = cdb_bus.valid;
    assign cdb_tag   = cdb_bus.tag;
    assign cdb_value = cdb_bus.value;

endmodule

`default_nettype wire

// File: source/cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
    input  logic       clock,
    input  logic       reset,
    unit_req.arbiter   alu_req,
    unit_req.arbiter   mul_req,
    cdb_if.arbiter     cdb
);

    logic                    prio_mul;   // multiplier wins a tie when set
    logic                    grant_alu;
    logic                    grant_mul;
    rs_types_pkg::cdb_word_t word;

    always_comb begin
        grant_alu = alu_req.request && (!mul_req.request || !prio_mul);
        grant_mul = mul_req.request && (!alu_req.request || prio_mul);
        if (grant_mul) begin
            word.tag   = mul_req.tag;
            word.value = mul_req.value;
        end else begin
            word.tag   = alu_req.tag;     // don't care when nothing is granted
            word.value = alu_req.value;
        end
    end

    assign alu_req.grant = grant_alu;
    assign mul_req.grant = grant_mul;

    // bus follows the grant in the same cycle
    assign cdb.valid = grant_alu || grant_mul;
    assign cdb.tag   = word.tag;
    assign cdb.value = word.value;

    // the unit just served drops to the back
    always_ff @(posedge clock) begin
        if (reset)          prio_mul <= 1'b0;
        else if (grant_alu) prio_mul <= 1'b1;
        else if (grant_mul) prio_mul <= 1'b0;
    end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module exec_unit #(
    parameter int STAGES = 1  // 1 builds the alu, more builds the multiplier
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  rs_types_pkg::issue_t in_op,
    output logic                 accept,   // front stage can load
    unit_req.requester           req
);

    logic [STAGES-1:0]  valid;
    logic [STAGES-1:0]  load;             // stage may take new content this edge
    rs_types_pkg::tag_t tag [STAGES];
    logic [`XLEN-1:0]   value [STAGES];
    logic [`XLEN-1:0]   result;

    if (STAGES == 1) begin : g_alu
        isa_pkg::rv_inst_u  inst;
        isa_pkg::alu_func_e func;
        logic               alt;          // sub / sra
        logic [`XLEN-1:0]   b;

        always_comb begin
            inst = in_op.inst;
            if (inst.r_view.opcode[5]) begin  // register-register
                func = isa_pkg::alu_func_e'(inst.r_view.funct3);
                alt  = inst.r_view.funct7[5];
                b    = in_op.rs2_value;
            end else begin                     // register-immediate
                func = isa_pkg::alu_func_e'(inst.i_view.funct3);
                alt  = 1'b0;
                b    = {{(`XLEN-12){inst.i_view.imm12[11]}}, inst.i_view.imm12};
            end
            case (func)
                isa_pkg::ALU_ADD: result = alt ? in_op.rs1_value - b : in_op.rs1_value + b;
                isa_pkg::ALU_SLL: result = in_op.rs1_value << b[4:0];
                isa_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}},
                                            $signed(in_op.rs1_value) < $signed(b)};
                isa_pkg::ALU_XOR: result = in_op.rs1_value ^ b;
                isa_pkg::ALU_SRL: result = alt ? `XLEN'($signed(in_op.rs1_value) >>> b[4:0])
                                               : in_op.rs1_value >> b[4:0];
                isa_pkg::ALU_OR:  result = in_op.rs1_value | b;
                isa_pkg::ALU_AND: result = in_op.rs1_value & b;
                default:          result = '0;  // sltu is not in the subset
            endcase
        end
    end else begin : g_mul
        assign result = in_op.rs1_value * in_op.rs2_value;  // low half only
    end

    // a stage frees when empty or when the one ahead of it moves
    always_comb begin
        load[STAGES-1] = !valid[STAGES-1] || req.grant;
        for (int s = STAGES - 2; s >= 0; s--) begin
            load[s] = !valid[s] || load[s+1];
        end
    end

    assign accept = load[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (load[0]) valid[0] <= in_valid;
            for (int s = 1; s < STAGES; s++) begin
                if (load[s]) valid[s] <= valid[s-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load[0]) begin
            tag[0]   <= in_op.dest;
            value[0] <= result;
        end
        for (int s = 1; s < STAGES; s++) begin
            if (load[s]) begin
                tag[s]   <= tag[s-1];
                value[s] <= value[s-1];
            end
        end
    end

    // last stage holds its word until the arbiter takes it
    assign req.request = valid[STAGES-1];
    assign req.tag     = tag[STAGES-1];
    assign req.value   = value[STAGES-1];

endmodule

`default_nettype wire

// File: source/rs_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module rs_bank (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch_valid,
    input  rs_types_pkg::dispatch_t dispatch,
    cdb_if.snoop                    cdb,
    input  logic                    accept,       // unit can take an op this cycle
    output logic                    issue_valid,
    output rs_types_pkg::issue_t    issue,
    output logic                    credit        // one pulse per freed slot
);

    localparam int IDX_BITS = $clog2(`RS_DEPTH);

    logic [`RS_DEPTH-1:0]  busy;
    logic [`RS_DEPTH-1:0]  ready;
    logic [`RS_DEPTH-1:0]  write;
    logic [`RS_DEPTH-1:0]  issue_sel;
    rs_types_pkg::issue_t  entries [`RS_DEPTH];
    logic [IDX_BITS-1:0]   seq [`RS_DEPTH];  // 0 is the oldest busy entry
    logic [IDX_BITS-1:0]   free_idx;
    logic [IDX_BITS-1:0]   pick_idx;
    logic [IDX_BITS:0]     busy_count;
    logic                  any_ready;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_entry
        assign write[i]     = dispatch_valid && (free_idx == IDX_BITS'(i));
        assign issue_sel[i] = issue_valid && (pick_idx == IDX_BITS'(i));

        rs_entry i_entry (
            .clock      (clock),
            .reset      (reset),
            .write      (write[i]),
            .write_data (dispatch),
            .issue      (issue_sel[i]),
            .cdb        (cdb),
            .busy       (busy[i]),
            .ready      (ready[i]),
            .entry      (entries[i])
        );
    end

    // lowest free slot, credits guarantee one exists on dispatch
    always_comb begin
        free_idx   = '0;
        busy_count = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) free_idx = IDX_BITS'(i);
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            busy_count += {{IDX_BITS{1'b0}}, busy[i]};
        end
    end

    // oldest ready entry has the smallest sequence number
    always_comb begin
        any_ready = 1'b0;
        pick_idx  = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ready[i] && (!any_ready || (seq[i] < seq[pick_idx]))) begin
                pick_idx  = IDX_BITS'(i);
                any_ready = 1'b1;
            end
        end
    end

    assign issue_valid = accept && any_ready;  // hold everything while the unit stalls
    assign issue       = entries[pick_idx];

    // new entry goes behind the survivors, younger ones close the gap on issue
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RS_DEPTH; i++) seq[i] <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (write[i]) begin
                    seq[i] <= IDX_BITS'(busy_count - {{IDX_BITS{1'b0}}, issue_valid});
                end else if (issue_valid && busy[i] && (seq[i] > seq[pick_idx])) begin
                    seq[i] <= seq[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) credit <= 1'b0;
        else       credit <= issue_valid;  // lands one cycle after the slot frees
    end

endmodule

`default_nettype wire

// File: source/rs_entry.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

module rs_entry (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    write,       // load a new instruction this edge
    input  rs_types_pkg::dispatch_t write_data,
    input  logic                    issue,       // selected by the bank to free the slot
    cdb_if.snoop                    cdb,
    output logic                    busy,
    output logic                    ready,
    output rs_types_pkg::issue_t    entry
);

    isa_pkg::rv_inst_u      inst;
    rs_types_pkg::operand_t rs1;
    rs_types_pkg::operand_t rs2;
    rs_types_pkg::tag_t     dest;
    logic                   rs1_hit;  // rs1 tag on the bus right now
    logic                   rs2_hit;

    // take the bus value if this operand is waiting on the broadcast tag
    function automatic rs_types_pkg::operand_t snoop_operand(
        input rs_types_pkg::operand_t op,
        input logic                   bus_valid,
        input rs_types_pkg::tag_t     bus_tag,
        input logic [`XLEN-1:0]       bus_value
    );
        rs_types_pkg::operand_t result;
        result = op;
        if (op.waiting && bus_valid && (op.tag == bus_tag)) begin
            result.waiting = 1'b0;
            result.value   = bus_value;
        end
        return result;
    endfunction

    assign rs1_hit = rs1.waiting && cdb.valid && (cdb.tag == rs1.tag);
    assign rs2_hit = rs2.waiting && cdb.valid && (cdb.tag == rs2.tag);

    // both sources known already or from this cycle's broadcast
    assign ready = busy && (!rs1.waiting || rs1_hit) && (!rs2.waiting || rs2_hit);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (write) begin
            busy <= 1'b1;
        end else if (issue) begin
            busy <= 1'b0;  // slot is free again after the issue edge
        end
    end

    // payload only meaningful while busy
    always_ff @(posedge clock) begin
        if (write) begin
            inst <= write_data.inst;
            dest <= write_data.dest;
            // a tag broadcast in the dispatch cycle is caught here
            rs1  <= snoop_operand(write_data.rs1, cdb.valid, cdb.tag, cdb.value);
            rs2  <= snoop_operand(write_data.rs2, cdb.valid, cdb.tag, cdb.value);
        end else if (busy) begin
            rs1  <= snoop_operand(rs1, cdb.valid, cdb.tag, cdb.value);
            rs2  <= snoop_operand(rs2, cdb.valid, cdb.tag, cdb.value);
        end
    end

    // bypass the live broadcast so a just-woken entry issues this cycle
    always_comb begin
        entry.inst = inst;
        entry.dest = dest;
        case ({rs1_hit, rs2_hit})
            2'b00: begin  // both from the entry
                entry.rs1_value = rs1.value;
                entry.rs2_value = rs2.value;
            end
            2'b01: begin  // rs2 from the bus
                entry.rs1_value = rs1.value;
                entry.rs2_value = cdb.value;
            end
            2'b10: begin  // rs1 from the bus
                entry.rs1_value = cdb.value;
                entry.rs2_value = rs2.value;
            end
            default: begin  // same tag feeds both sources
                entry.rs1_value = cdb.value;
                entry.rs2_value = cdb.value;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/cdb_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "rs_defines.svh"

// the shared result bus, one driver and many listeners
interface cdb_if;
    logic               valid;
    rs_types_pkg::tag_t tag;
    logic [`XLEN-1:0]   value;

    modport arbiter (output valid, tag, value);
    modport snoop (input valid, tag, value);
endinterface

// one unit's finished result waiting for the bus
interface unit_req;
    logic               request;  // held with tag/value until granted
    logic               grant;    // transfer happens in this cycle
    rs_types_pkg::tag_t tag;
    logic [`XLEN-1:0]   value;

    modport requester (output request, tag, value, input grant);
    modport arbiter (input request, tag, value, output grant);
endinterface

`default_nettype wire

// File: source/rs_types_pkg.sv
`default_nettype none

`include "rs_defines.svh"

package rs_types_pkg;

    // name of a result in flight
    typedef logic [`TAG_BITS-1:0] tag_t;

    // source operand, value only meaningful once waiting is clear
    typedef struct packed {
        logic              waiting;
        tag_t              tag;    // producer to watch for on the cdb
        logic [`XLEN-1:0]  value;
    } operand_t;

    // what the dispatcher hands to a station
    typedef struct packed {
        isa_pkg::rv_inst_u inst;
        operand_t          rs1;
        operand_t          rs2;
        tag_t              dest;   // tag this instruction will broadcast
    } dispatch_t;

    // what a station hands to its unit, operands fully resolved
    typedef struct packed {
        isa_pkg::rv_inst_u inst;
        logic [`XLEN-1:0]  rs1_value;
        logic [`XLEN-1:0]  rs2_value;
        tag_t              dest;
    } issue_t;

    // one broadcast on the common data bus
    typedef struct packed {
        tag_t              tag;
        logic [`XLEN-1:0]  value;
    } cdb_word_t;

endpackage

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // R-type layout, used for register-register ops and mul
    typedef struct packed {
        logic [6:0] funct7;  // bit 5 selects sub / sra
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // I-type layout, immediate takes the place of funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;  // sign extended into operand b
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // same 32 bits seen two ways, opcode[5] tells which one applies
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } rv_inst_u;

    // funct3 values of the supported subset
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,  // add, sub, addi
        ALU_SLL = 3'b001,
        ALU_SLT = 3'b010,  // signed compare
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,  // srl or sra
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_func_e;

endpackage

`default_nettype wire

// File: source/rs_defines.svh
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// datapath width of operands and results
`define XLEN 32

// result tag width, 16 names in flight
`define TAG_BITS 4

// slots in each reservation station
`define RS_DEPTH 4

// latency of the multiplier pipeline
`define MUL_STAGES 3

`endif
